//--- common/life_config.svh
////////////////////////////////////////
// board geometry and register map defines
////////////////////////////////////////
`ifndef LIFE_CONFIG_SVH
`define LIFE_CONFIG_SVH

// board size
`define LIFE_COLS      32   // cells per row, also bus data width
`define LIFE_ROWS      16   // rows per board, one bank
`define LIFE_ROW_BITS  4    // row index width

// wishbone word address map
`define LIFE_ADR_BITS  5    // rows 0..15 then the control word
`define LIFE_CTRL_ADR  16   // control/status, first word above the rows

// control word bits
//   write bit 0   start one generation pass
//   read bit 0    busy

`endif

//--- common/life_geom_pkg.sv
////////////////////////////////////////
// board types: row word, row index,
// column tally and the three-row window
////////////////////////////////////////
`include "life_config.svh"

package life_geom_pkg;

	// one board row
	// bit n is column n, 1 = alive
	typedef logic [`LIFE_COLS-1:0] row_t;

	typedef logic [`LIFE_ROW_BITS-1:0] row_idx_t; // row within a bank

	// live count of three stacked cells, per column
	// 0..3 fits in two bits
	typedef logic [`LIFE_COLS-1:0][1:0] tally_row_t;

	// rows feeding the rule stage
	typedef struct packed {
		row_t above;   // oldest read
		row_t centre;  // row whose next state is computed
		row_t below;   // newest read
	} window_t;

endpackage

//--- common/life_bus_pkg.sv
////////////////////////////////////////
// wishbone request/response structs
// and the internal host row access
////////////////////////////////////////
`include "life_config.svh"

package life_bus_pkg;

	// master side, held until ack
	typedef struct packed {
		logic                      cyc;
		logic                      stb;
		logic                      we;
		logic [`LIFE_ADR_BITS-1:0] adr;    // word address
		logic [`LIFE_COLS-1:0]     dat_w;
	} wb_req_t;

	// slave side
	typedef struct packed {
		logic                  ack;    // one cycle per transfer
		logic [`LIFE_COLS-1:0] dat_r;
	} wb_rsp_t;

	// row access toward the pass sequencer
	// valid stays up until acc_done
	typedef struct packed {
		logic                    valid;
		logic                    we;     // 1 = write data to row
		life_geom_pkg::row_idx_t row;    // row in the current bank
		life_geom_pkg::row_t     data;   // write data
	} host_acc_t;

endpackage

//--- life_engine/row_ram.sv
////////////////////////////////////////
// two-bank row memory, registered read
////////////////////////////////////////
`timescale 1ns/1ns
`include "life_config.svh"

module row_ram (
	input  logic                    clk,
	input  logic                    rd_bank,
	input  life_geom_pkg::row_idx_t rd_row,
	output life_geom_pkg::row_t     rd_data,
	input  logic                    wr_en,
	input  logic                    wr_bank,
	input  life_geom_pkg::row_idx_t wr_row,
	input  logic                    wr_sel_host,
	input  life_geom_pkg::row_t     host_data,
	input  life_geom_pkg::row_t     gen_data
);

	import life_geom_pkg::*;

	// bank is the top address bit
	row_t mem [0:2*`LIFE_ROWS-1];
	row_t wr_data;

	// host init data or the new generation
	assign wr_data = wr_sel_host ? host_data : gen_data;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[{wr_bank, wr_row}] <= wr_data;
		rd_data <= mem[{rd_bank, rd_row}];  // data one cycle after address
	end

endmodule

//--- life_engine/gen_stage.sv
////////////////////////////////////////
// three-row window, column tally,
// wrapping neighbour sum and life rule
////////////////////////////////////////
`timescale 1ns/1ns
`include "life_config.svh"

module gen_stage (
	input  logic                clk,
	input  logic                sh,        // advance the whole pipe
	input  life_geom_pkg::row_t rd_data,   // row from the ram
	output life_geom_pkg::row_t next_row   // new generation, to ram write data
);

	import life_geom_pkg::*;

	window_t                     win;       // above / centre / below
	tally_row_t                  tally;     // column counts of win
	tally_row_t                  tally_q;
	row_t                        centre_q;  // centre row matching tally_q
	logic [`LIFE_COLS-1:0][3:0]  add9;      // 3x3 count incl. the cell
	row_t                        live;      // rule result

	////////////////////////////////////////
	// row window
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (sh) begin
			win.above  <= win.centre;
			win.centre <= win.below;
			win.below  <= rd_data;  // newest row in at the bottom
		end
	end

	////////////////////////////////////////
	// vertical tally
	////////////////////////////////////////

	always_comb begin
		for (int xx = 0; xx < `LIFE_COLS; xx++) begin
			tally[xx] = {1'b0, win.above[xx]} +
			            {1'b0, win.centre[xx]} +
			            {1'b0, win.below[xx]};   // max 3
		end
	end

	// registered on the shift after the window fills
	always_ff @(posedge clk) begin
		if (sh) begin
			tally_q  <= tally;
			centre_q <= win.centre;  // keep cell state in step with its tally
		end
	end

	////////////////////////////////////////
	// horizontal sum and rule
	////////////////////////////////////////

	always_comb begin
		int lft;
		int rgt;
		for (int xx = 0; xx < `LIFE_COLS; xx++) begin
			lft = (xx == 0) ? `LIFE_COLS - 1 : xx - 1;   // left wrap
			rgt = (xx == `LIFE_COLS - 1) ? 0 : xx + 1;   // right wrap
			add9[xx] = {2'b00, tally_q[lft]} +
			           {2'b00, tally_q[xx]} +
			           {2'b00, tally_q[rgt]};
			// total 3 → born or survives with 2 neighbours
			// total 4 → survives with 3 neighbours, only if alive
			live[xx] = (add9[xx] == 4'd3) ||
			           ((add9[xx] == 4'd4) && centre_q[xx]);
		end
	end

	// result register, written to the ram by the sequencer
	always_ff @(posedge clk) begin
		if (sh)
			next_row <= live;
	end

endmodule

//--- life_engine/pass_sequencer.sv
////////////////////////////////////////
// pass control: row read order, delayed
// row writes, ram port sharing, bank swap
////////////////////////////////////////
`timescale 1ns/1ns
`include "life_config.svh"

module pass_sequencer (
	input  logic                    clk,
	input  logic                    rst_n,
	input  life_bus_pkg::host_acc_t acc,
	output logic                    acc_done,
	input  logic                    start,
	output logic                    busy,
	output life_geom_pkg::row_idx_t rd_row,
	output logic                    rd_bank,
	output logic                    wr_en,
	output life_geom_pkg::row_idx_t wr_row,
	output logic                    wr_bank,
	output logic                    wr_sel_host,  // 1 = host data, 0 = next_row
	output logic                    sh
);

	import life_geom_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_READ,   // streaming rows into the window
		S_DRAIN   // pipeline emptying, writes still going
	} state_t;

	// pass step numbers, step 0 is the first busy cycle
	localparam logic [`LIFE_ROW_BITS:0] RD_LAST   = `LIFE_ROWS + 1; // rows+2 reads
	localparam logic [`LIFE_ROW_BITS:0] SH_LAST   = `LIFE_ROWS + 3; // last step arming sh
	localparam logic [`LIFE_ROW_BITS:0] WR_LAT    = 6;              // first read to first write
	localparam logic [`LIFE_ROW_BITS:0] PASS_LAST = `LIFE_ROWS + 5; // last write step

	state_t                   state;
	logic [`LIFE_ROW_BITS:0]  step;     // cycle within the pass
	row_idx_t                 rd_ord;   // wrapping read order
	row_idx_t                 wr_cnt;   // next row to write
	logic                     bank;     // bank holding the current board
	logic                     rd_pend;  // host read in flight in the ram
	logic                     host_go;
	logic                     host_wr;
	logic                     host_rd;
	logic                     pass_wr;

	////////////////////////////////////////
	// read order and grants
	////////////////////////////////////////

	// last row, rows 0..last, row 0 again
	always_comb begin
		if (step == '0)
			rd_ord = row_idx_t'(`LIFE_ROWS - 1);
		else if (step == RD_LAST)
			rd_ord = '0;
		else
			rd_ord = row_idx_t'(step - 1'b1);
	end

	// host gets the ram only between passes
	assign host_go = (state == S_IDLE) && acc.valid && !acc_done && !rd_pend;
	assign host_wr = host_go && acc.we;
	assign host_rd = host_go && !acc.we;
	assign pass_wr = (state != S_IDLE) && (step >= WR_LAT);  // next_row valid from here

	////////////////////////////////////////
	// ram ports
	////////////////////////////////////////

	assign busy        = (state != S_IDLE);
	assign rd_row      = (state == S_READ) ? rd_ord : acc.row;
	assign rd_bank     = bank;                         // always the current board
	assign wr_en       = pass_wr || host_wr;
	assign wr_sel_host = (state == S_IDLE);
	assign wr_row      = (state == S_IDLE) ? acc.row : wr_cnt;
	assign wr_bank     = (state == S_IDLE) ? bank : ~bank;  // pass fills the other bank

	////////////////////////////////////////
	// state
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= S_IDLE;
			step     <= '0;
			wr_cnt   <= '0;
			bank     <= 1'b0;
			sh       <= 1'b0;
			rd_pend  <= 1'b0;
			acc_done <= 1'b0;
		end else begin
			// shift one cycle behind each read, two extra to flush
			sh       <= (state != S_IDLE) && (step <= SH_LAST);
			rd_pend  <= host_rd;
			acc_done <= host_wr || rd_pend;  // read done once ram data is out

			if (pass_wr)
				wr_cnt <= wr_cnt + 1'b1;

			case (state)
				S_IDLE: begin
					if (start) begin   // start while busy never gets here
						state  <= S_READ;
						step   <= '0;
						wr_cnt <= '0;
					end
				end
				S_READ: begin
					step <= step + 1'b1;
					if (step == RD_LAST)
						state <= S_DRAIN;
				end
				S_DRAIN: begin
					step <= step + 1'b1;
					if (step == PASS_LAST) begin
						state <= S_IDLE;
						bank  <= ~bank;   // new board becomes current
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

//--- hw/host_port.sv
////////////////////////////////////////
// wishbone classic slave: row window,
// control/status word, pending row access
////////////////////////////////////////
`timescale 1ns/1ns
`include "life_config.svh"

module host_port (
	input  logic                    clk,
	input  logic                    rst_n,
	input  life_bus_pkg::wb_req_t   wb_i,
	output life_bus_pkg::wb_rsp_t   wb_o,
	output life_bus_pkg::host_acc_t acc,       // row access toward sequencer
	input  logic                    acc_done,  // access served
	input  life_geom_pkg::row_t     rd_data,   // ram read port output
	output logic                    start,     // one-cycle pass start
	input  logic                    busy
);

	import life_geom_pkg::*;

	logic req;       // live request not yet answered
	logic row_hit;   // word lies in the row window
	logic ctrl_hit;  // control/status word
	logic take_row;  // latch a new row access
	logic reg_ack;   // control or unmapped word answer
	row_t dat_q;     // read data returned with ack

	////////////////////////////////////////
	// address decode
	////////////////////////////////////////

	assign req      = wb_i.cyc && wb_i.stb && !wb_o.ack;
	assign row_hit  = (wb_i.adr < `LIFE_ROWS);
	assign ctrl_hit = (wb_i.adr == `LIFE_CTRL_ADR);
	assign take_row = req && row_hit && !acc.valid; // one access at a time

	////////////////////////////////////////
	// pending access, start, register ack
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		// access payload, loaded once per request
		if (take_row) begin
			acc.we   <= wb_i.we;
			acc.row  <= row_idx_t'(wb_i.adr);  // low bits pick the row
			acc.data <= wb_i.dat_w;
		end

		if (!rst_n) begin
			acc.valid <= 1'b0;
			reg_ack   <= 1'b0;
			start     <= 1'b0;
		end else begin
			// non-row words answer the next cycle
			reg_ack <= req && !row_hit;
			// bit 0 written as 1 kicks off a pass
			start   <= req && ctrl_hit && wb_i.we && wb_i.dat_w[0];

			if (acc_done)
				acc.valid <= 1'b0;   // served, drop it
			else if (take_row)
				acc.valid <= 1'b1;   // held here while a pass runs
		end
	end

	////////////////////////////////////////
	// read data
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (req && !row_hit) begin
			if (ctrl_hit)
				dat_q <= {{(`LIFE_COLS-1){1'b0}}, busy};  // status word
			else
				dat_q <= '0;   // unmapped reads as zero
		end else if (acc.valid && !acc.we) begin
			dat_q <= rd_data;  // follows ram, settled before acc_done
		end
	end

	// ack straight off the served flags, only inside a cycle
	assign wb_o = '{
		ack:   (reg_ack || acc_done) && wb_i.cyc && wb_i.stb,
		dat_r: dat_q
	};

endmodule

//--- hw/life_top.sv
////////////////////////////////////////
// life engine top: host port, pass
// sequencer, row ram and generation stage
////////////////////////////////////////
`timescale 1ns/1ns

module life_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  life_bus_pkg::wb_req_t wb_i,
	output life_bus_pkg::wb_rsp_t wb_o
);

	import life_geom_pkg::*;
	import life_bus_pkg::*;

	// host side
	host_acc_t acc;
	logic      acc_done;
	logic      start;
	logic      busy;

	// ram ports
	row_idx_t  rd_row;
	logic      rd_bank;
	row_t      rd_data;
	logic      wr_en;
	row_idx_t  wr_row;
	logic      wr_bank;
	logic      wr_sel_host;

	// datapath
	logic      sh;        // window shift enable
	row_t      next_row;  // new generation row

	host_port u_host (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_i     (wb_i),
		.wb_o     (wb_o),
		.acc      (acc),
		.acc_done (acc_done),
		.rd_data  (rd_data),
		.start    (start),
		.busy     (busy)
	);

	pass_sequencer u_seq (
		.clk         (clk),
		.rst_n       (rst_n),
		.acc         (acc),
		.acc_done    (acc_done),
		.start       (start),
		.busy        (busy),
		.rd_row      (rd_row),
		.rd_bank     (rd_bank),
		.wr_en       (wr_en),
		.wr_row      (wr_row),
		.wr_bank     (wr_bank),
		.wr_sel_host (wr_sel_host),
		.sh          (sh)
	);

	row_ram u_ram (
		.clk         (clk),
		.rd_bank     (rd_bank),
		.rd_row      (rd_row),
		.rd_data     (rd_data),
		.wr_en       (wr_en),
		.wr_bank     (wr_bank),
		.wr_row      (wr_row),
		.wr_sel_host (wr_sel_host),
		.host_data   (acc.data),   // init / host row writes
		.gen_data    (next_row)
	);

	gen_stage u_gen (
		.clk      (clk),
		.sh       (sh),
		.rd_data  (rd_data),
		.next_row (next_row)
	);

endmodule

//--- testbench/life_assert.sv
////////////////////////////////////////
// bound checks on the wishbone answer,
// idle ram writes and the pass end
////////////////////////////////////////
`timescale 1ns/1ns
`include "life_config.svh"

module life_assert (
	input logic clk,
	input logic rst_n,
	input logic ack_src,   // served flag before the cycle gate
	input logic cyc,
	input logic stb,
	input logic busy,
	input logic wr_en,
	input logic host_wr,   // host row write waiting
	input logic acc_done,  // host access served
	input logic last_row   // write address is the bottom row
);

	int fails = 0;  // failed assertions, summed by the testbench

	// slave answers only inside a live cycle
	ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		ack_src |-> (cyc && stb))
		else begin
			$error("ack source raised without cyc and stb");
			fails++;
		end

	// between passes the ram is written once per host write, then served
	idle_write: assert property (@(posedge clk) disable iff (!rst_n)
		(!busy && wr_en) |-> host_wr ##1 (acc_done && !wr_en))
		else begin
			$error("idle ram write not a single served host write");
			fails++;
		end

	// pass ends right after the bottom row is stored
	pass_end: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(busy) |-> $past(wr_en && last_row))
		else begin
			$error("busy dropped before the last row write");
			fails++;
		end

endmodule

// wishbone side with the pass checks tied off
bind host_port life_assert u_bus_chk (
	.clk      (clk),
	.rst_n    (rst_n),
	.ack_src  (reg_ack || acc_done),
	.cyc      (wb_i.cyc),
	.stb      (wb_i.stb),
	.busy     (1'b0),
	.wr_en    (1'b0),
	.host_wr  (1'b0),
	.acc_done (1'b0),
	.last_row (1'b0)
);

// sequencer side with the bus checks tied off
bind pass_sequencer life_assert u_seq_chk (
	.clk      (clk),
	.rst_n    (rst_n),
	.ack_src  (1'b0),
	.cyc      (1'b0),
	.stb      (1'b0),
	.busy     (busy),
	.wr_en    (wr_en),
	.host_wr  (acc.valid && acc.we),
	.acc_done (acc_done),
	.last_row (wr_row == (`LIFE_ROWS - 1))
);

//--- testbench/tb_life.sv
////////////////////////////////////////
// life engine testbench with bus tasks,
// torus model, directed tests, watchdog
////////////////////////////////////////
`timescale 1ns/1ns
`include "life_config.svh"

module tb_life;

	import life_geom_pkg::*;
	import life_bus_pkg::*;

	localparam int N_TESTS   = 5;
	localparam int N_PASSES  = 4;   // longest test
	localparam int WD_CYCLES = N_TESTS * N_PASSES * (`LIFE_ROWS + 40) + 2000;

	logic        clk;
	logic        rst_n;
	wb_req_t     wb_i;
	wb_rsp_t     wb_o;
	row_t        board [0:`LIFE_ROWS-1];  // reference board
	logic [15:0] lfsr;
	int          errors;
	int          checks;

	life_top uut (
		.clk   (clk),
		.rst_n (rst_n),
		.wb_i  (wb_i),
		.wb_o  (wb_o)
	);

	always #2 clk = ~clk;  // 4 ns period

	////////////////////////////////////////
	// random rows and reference model
	////////////////////////////////////////

	// galois step with taps 16/14/13/11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic row_t random_row();
		row_t r;
		for (int c = 0; c < `LIFE_COLS; c++) begin
			lfsr = lfsr_step(lfsr);  // one step per cell
			r[c] = lfsr[0];
		end
		return r;
	endfunction

	task automatic clear_board();
		for (int r = 0; r < `LIFE_ROWS; r++)
			board[r] = '0;
	endtask

	// one generation on the torus with eight neighbours
	task automatic model_step();
		row_t nxt [0:`LIFE_ROWS-1];
		int   cnt;
		int   rr;
		int   cc;
		for (int r = 0; r < `LIFE_ROWS; r++) begin
			for (int c = 0; c < `LIFE_COLS; c++) begin
				cnt = 0;
				for (int dr = -1; dr <= 1; dr++) begin
					for (int dc = -1; dc <= 1; dc++) begin
						rr = (r + dr + `LIFE_ROWS) % `LIFE_ROWS;  // wrap rows
						cc = (c + dc + `LIFE_COLS) % `LIFE_COLS;  // wrap cols
						if (dr != 0 || dc != 0)
							cnt += board[rr][cc];
					end
				end
				nxt[r][c] = (cnt == 3) || (cnt == 2 && board[r][c]);
			end
		end
		for (int r = 0; r < `LIFE_ROWS; r++)
			board[r] = nxt[r];
	endtask

	////////////////////////////////////////
	// wishbone master
	////////////////////////////////////////

	// hold the request until ack is seen mid-cycle
	task automatic wait_ack(output row_t dat);
		@(negedge clk);
		while (!wb_o.ack)
			@(negedge clk);
		dat = wb_o.dat_r;
		@(posedge clk);
		wb_i <= '0;  // end of cycle
	endtask

	task automatic wb_write(input logic [`LIFE_ADR_BITS-1:0] adr, input row_t dat);
		row_t unused;
		@(posedge clk);
		wb_i <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat_w: dat};
		wait_ack(unused);
	endtask

	task automatic wb_read(input logic [`LIFE_ADR_BITS-1:0] adr, output row_t dat);
		@(posedge clk);
		wb_i <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat_w: '0};
		wait_ack(dat);
	endtask

	////////////////////////////////////////
	// compare and board helpers
	////////////////////////////////////////

	task automatic check_row(input string name, input row_t exp, input row_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_status(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic load_board();
		for (int r = 0; r < `LIFE_ROWS; r++)
			wb_write(`LIFE_ADR_BITS'(r), board[r]);
	endtask

	task automatic compare_board(input string name);
		row_t got;
		for (int r = 0; r < `LIFE_ROWS; r++) begin
			wb_read(`LIFE_ADR_BITS'(r), got);
			check_row($sformatf("%s row %0d", name, r), board[r], got);
		end
	endtask

	// poll status until the pass is over
	task automatic wait_idle();
		row_t st;
		int   polls;
		polls = 0;
		do begin
			wb_read(`LIFE_CTRL_ADR, st);
			polls++;
		end while (st[0] && polls < 200);
		if (st[0]) begin
			errors++;
			$display("busy still set after %0d status reads", polls);
		end
	endtask

	task automatic run_pass();
		wb_write(`LIFE_CTRL_ADR, 32'h1);  // bit 0 starts a pass
		wait_idle();
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic rw_roundtrip();
		for (int r = 0; r < `LIFE_ROWS; r++)
			board[r] = random_row();
		board[0]            = 32'h8000_0001;  // both edge columns
		board[`LIFE_ROWS-1] = 32'hA5A5_5A5A;
		load_board();
		compare_board("rw");
	endtask

	task automatic blinker_phases();
		clear_board();
		board[7] = 32'h0000_0E00;  // cols 9..11
		load_board();
		run_pass();
		clear_board();
		board[6] = 32'h0000_0400;  // vertical phase
		board[7] = 32'h0000_0400;
		board[8] = 32'h0000_0400;
		compare_board("blinker gen 1");
		run_pass();
		clear_board();
		board[7] = 32'h0000_0E00;  // back to horizontal
		compare_board("blinker gen 2");
	endtask

	// heads up and toward col 0 across both edges
	task automatic glider_wrap();
		clear_board();
		board[0] = 32'h0000_0007;
		board[1] = 32'h0000_0001;
		board[2] = 32'h0000_0002;
		load_board();
		for (int g = 1; g <= 4; g++) begin
			run_pass();
			model_step();
			compare_board($sformatf("glider gen %0d", g));
		end
	endtask

	task automatic random_board();
		for (int r = 0; r < `LIFE_ROWS; r++)
			board[r] = random_row();
		load_board();
		for (int g = 1; g <= 3; g++) begin
			run_pass();
			model_step();
			compare_board($sformatf("random gen %0d", g));
		end
	endtask

	task automatic busy_stall();
		row_t st;
		row_t got;
		wb_write(`LIFE_CTRL_ADR, 32'h1);
		wb_read(`LIFE_CTRL_ADR, st);
		check_status("busy after start", 1'b1, st[0]);
		wb_read(`LIFE_ADR_BITS'(5), got);  // stalls until the pass ends
		model_step();
		check_row("read during busy", board[5], got);
		wb_read(`LIFE_CTRL_ADR, st);
		check_status("busy after pass", 1'b0, st[0]);
	endtask

	////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////

	initial begin
		clk    = 1'b0;
		rst_n  = 1'b0;
		wb_i   = '0;
		lfsr   = 16'd84;
		errors = 0;
		checks = 0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		rw_roundtrip();
		blinker_phases();
		glider_wrap();
		random_board();
		busy_stall();   // continues from the random board
		errors += uut.u_host.u_bus_chk.fails + uut.u_seq.u_seq_chk.fails;
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial begin
		repeat (WD_CYCLES) @(posedge clk);
		$display("timeout: run still going after %0d cycles", WD_CYCLES);
		$display("Test failures found");
		$finish;
	end

endmodule

//--- project.f
+incdir+common
common/life_geom_pkg.sv
common/life_bus_pkg.sv
life_engine/row_ram.sv
life_engine/gen_stage.sv
life_engine/pass_sequencer.sv
hw/host_port.sv
hw/life_top.sv
testbench/life_assert.sv
testbench/tb_life.sv

//--- Bender.yml
package:
  name: life_engine

sources:
  - include_dirs:
      - common
    files:
      - common/life_geom_pkg.sv
      - common/life_bus_pkg.sv
      - life_engine/row_ram.sv
      - life_engine/gen_stage.sv
      - life_engine/pass_sequencer.sv
      - hw/host_port.sv
      - hw/life_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/life_assert.sv
      - testbench/tb_life.sv
